//--- hw/pm_pkg.sv
`default_nettype none

package pm_pkg;

	// cycle-end one-shot length in clock cycles
	localparam int kc_ticks = 3;
	// cycle-start one-shot length in clock cycles
	localparam int pc_ticks = 2;

	// shared down-counter for both one-shots
	localparam int tmr_width = 2;
	// reload values, counter runs down to zero
	localparam logic [tmr_width-1:0] kc_last = tmr_width'(kc_ticks - 1);
	localparam logic [tmr_width-1:0] pc_last = tmr_width'(pc_ticks - 1);

	// group counter, selects one of eight general registers
	localparam int lg_width = 3;
	// step counter for shifts and register-group transfers
	localparam int lk_width = 4;
	// premodification counter
	localparam int mc_width = 2;

	// instruction word, msb is ir0 in machine numbering
	typedef union packed {
		// register form: opcode, d flag, a/b/c register fields
		struct packed {
			logic [5:0] op;
			logic       d;
			logic [2:0] a;
			logic [2:0] b;
			logic [2:0] c;
		} ir_regs;
		// shift form: count split into ir6 and ir13..ir15
		struct packed {
			logic [5:0] op;
			logic       count_hi;
			logic [5:0] pad;
			logic [2:0] count_lo;
		} ir_shift;
	} ir_word_t;

endpackage

`default_nettype wire

//--- hw/pm_cycle_if.sv
`default_nettype none

// cycle state from the kc/pc timers to the run control
interface pm_cycle_if;

	// cycle-end pulse
	logic kc;
	// cycle-start pulse
	logic pc;
	// next cycle is an instruction fetch
	logic pr;
	// next cycle is an interrupt receive
	logic przerw;

	// timer side owns all four
	modport timer (
		output kc,
		output pc,
		output pr,
		output przerw
	);

	// control side only decodes them
	modport ctl (
		input kc,
		input pc,
		input pr,
		input przerw
	);

endinterface

`default_nettype wire

//--- hw/pm_kcpc.sv
`default_nettype none

module pm_kcpc (
	input  wire        __clk,
	input  wire        M95_10,
	input  wire        ekc,
	input  wire        dpr,
	input  wire        dprzerw,
	pm_cycle_if.timer  cyc
);

	// one-shot states
	logic kc_q;
	logic pc_q;
	// latched cycle type
	logic pr_q;
	logic przerw_q;
	// ticks left in the active one-shot
	logic [pm_pkg::tmr_width-1:0] tmr;

	// kc then pc, one counter shared by both phases
	always_ff @(posedge __clk or negedge M95_10) begin
		if (!M95_10) begin
			kc_q     <= 1'b0;
			pc_q     <= 1'b0;
			pr_q     <= 1'b0;
			przerw_q <= 1'b0;
			tmr      <= '0;
		end else if (kc_q) begin
			if (tmr == '0) begin
				// kc done, hand over to pc
				kc_q     <= 1'b0;
				pc_q     <= 1'b1;
				tmr      <= pm_pkg::pc_last;
				// cycle type sampled on pc rise
				pr_q     <= dpr;
				przerw_q <= dprzerw;
			end else begin
				tmr <= tmr - 1'b1;
			end
		end else if (pc_q) begin
			if (tmr == '0)
				pc_q <= 1'b0;
			else
				tmr <= tmr - 1'b1;
		end else if (ekc) begin
			// idle, trigger cycle end
			kc_q <= 1'b1;
			tmr  <= pm_pkg::kc_last;
		end
	end

	assign cyc.kc     = kc_q;
	assign cyc.pc     = pc_q;
	assign cyc.pr     = pr_q;
	assign cyc.przerw = przerw_q;

	// the two one-shots never overlap
	a_kc_pc_excl: assert property (@(posedge __clk) disable iff (!M95_10)
		!(kc_q && pc_q))
		else $error("kc and pc high together");

	// pc only starts as kc ends
	a_pc_after_kc: assert property (@(posedge __clk) disable iff (!M95_10)
		$rose(pc_q) |-> $fell(kc_q))
		else $error("pc rose without kc falling");

endmodule

`default_nettype wire

//--- hw/pm_group_cnt.sv
`default_nettype none

module pm_group_cnt (
	input  wire                          __clk,
	input  wire                          M95_10,
	input  pm_pkg::ir_word_t             ir,
	input  wire                          slg,
	input  wire                          strob1,
	input  wire                          lg_inc,
	input  wire                          i1,
	input  wire                          w_phase,
	output logic [pm_pkg::lg_width-1:0]  lg,
	output logic [pm_pkg::lg_width-1:0]  reg_sel
);

	// clear beats load, load beats increment
	always_ff @(posedge __clk or negedge M95_10) begin
		if (!M95_10) begin
			lg <= '0;
		end else if (i1) begin
			lg <= '0;
		end else if (slg) begin
			// preload from the a field
			lg <= ir.ir_regs.a;
		end else if (strob1 && lg_inc) begin
			// next register of the group
			lg <= lg + 1'b1;
		end
	end

	// selector only during a w-bus phase
	always_comb begin
		if (w_phase)
			reg_sel = lg;
		else
			reg_sel = '0;
	end

	// preload and clear come from exclusive states
	a_slg_i1_excl: assert property (@(posedge __clk) disable iff (!M95_10)
		!(slg && i1))
		else $error("slg and i1 in the same cycle");

endmodule

`default_nettype wire

//--- hw/pm_step_cnt.sv
`default_nettype none

module pm_step_cnt (
	input  wire                          __clk,
	input  wire                          M95_10,
	input  pm_pkg::ir_word_t             ir,
	input  wire                          shc,
	input  wire                          lk_load,
	input  wire                          strob1,
	input  wire                          lk_dec,
	output logic [pm_pkg::lk_width-1:0]  lk,
	output logic                         lk_zero
);

	logic [pm_pkg::lk_width-1:0] lk_in;

	// shift count or register count from b field
	assign lk_in = shc ? {ir.ir_shift.count_hi, ir.ir_shift.count_lo}
	                   : {1'b0, ir.ir_regs.b};

	always_ff @(posedge __clk or negedge M95_10) begin
		if (!M95_10) begin
			lk <= '0;
		end else if (lk_load) begin
			lk <= lk_in;
		end else if (strob1 && lk_dec && !lk_zero) begin
			// count down, hold at zero
			lk <= lk - 1'b1;
		end
	end

	assign lk_zero = (lk == '0);

	// saturation, no wrap to all ones
	a_no_wrap: assert property (@(posedge __clk) disable iff (!M95_10)
		(lk == '0 && !lk_load) |=> lk != '1)
		else $error("step counter wrapped from zero");

endmodule

`default_nettype wire

//--- hw/pm_ctl.sv
`default_nettype none

module pm_ctl (
	input  wire        __clk,
	input  wire        M95_10,
	input  wire        start,
	input  wire        stop,
	input  wire        clo,
	input  wire        hlt_n,
	input  wire        hlt,
	input  wire        wx,
	input  wire        cycle,
	input  wire        irq,
	input  wire        strob1,
	input  wire        strob2,
	input  wire        ekc_1,
	input  wire        ekc_2,
	input  wire        md,
	input  wire        p4,
	input  wire        p2,
	input  wire        ssp,
	input  wire        j,
	input  wire        bcoc,
	input  wire        zs,
	pm_cycle_if.ctl    cyc,
	output logic       ekc,
	output logic       dpr,
	output logic       dprzerw,
	output logic       run,
	output logic       wait_q,
	output logic       sp0,
	output logic       sp1,
	output logic       si1,
	output logic       p,
	output logic       mc_3
);

	logic startq;
	logic cycle_q;
	logic mc_0;
	logic [pm_pkg::mc_width-1:0] mc;

	// start ff
	// stop, clear or halt switch drops it
	always_ff @(posedge __clk or negedge M95_10) begin
		if (!M95_10)
			startq <= 1'b0;
		else if (stop || clo || hlt_n)
			startq <= 1'b0;
		else if (start)
			startq <= 1'b1;
	end

	// wait ff
	// hlt taken at wx, interrupt receive releases it
	always_ff @(posedge __clk or negedge M95_10) begin
		if (!M95_10)
			wait_q <= 1'b0;
		else if (si1)
			wait_q <= 1'b0;
		else if (wx)
			wait_q <= hlt;
	end

	// single cycle request ff
	always_ff @(posedge __clk or negedge M95_10) begin
		if (!M95_10)
			cycle_q <= 1'b0;
		else if (cycle)
			cycle_q <= 1'b1;
		else if (strob2)
			cycle_q <= 1'b0;
	end

	assign run = startq & ~wait_q;

	// next cycle fetches if running or single-stepping
	assign dpr = run | cycle_q;
	// interrupt only outside branch and premodification
	assign dprzerw = (cycle_q | startq) & irq & ~p & mc_0;
	// cycle end requests
	assign ekc = ekc_1 | ekc_2;

	// cycle type while pc is high
	assign sp0 = cyc.pc & ~cyc.pr & ~cyc.przerw;
	assign sp1 = cyc.pc & cyc.pr & ~cyc.przerw;
	assign si1 = cyc.pc & cyc.przerw;

	// premodification counter
	// counts at wx of a modified instruction, saturates at 3
	always_ff @(posedge __clk or negedge M95_10) begin
		if (!M95_10)
			mc <= '0;
		else if (p4 && !md)
			mc <= '0;
		else if (strob1 && wx && md && !mc_3)
			mc <= mc + 1'b1;
	end

	assign mc_3 = (mc == '1);
	assign mc_0 = (mc == '0);

	// branch indicator
	// p2 clears, otherwise ssp loads the condition
	always_ff @(posedge __clk or negedge M95_10) begin
		if (!M95_10) begin
			p <= 1'b0;
		end else if (strob1) begin
			if (p2)
				p <= 1'b0;
			else if (ssp)
				p <= (~j & bcoc) | zs;
		end
	end

	// at most one cycle type per pc pulse
	a_cycle_onehot: assert property (@(posedge __clk) disable iff (!M95_10)
		$onehot0({sp0, sp1, si1}))
		else $error("sp0/sp1/si1 not one-hot");

endmodule

`default_nettype wire

//--- hw/pm_top.sv
`default_nettype none

module pm_top (
	input  wire         __clk,
	input  wire         M95_10,
	input  wire         start,
	input  wire         stop,
	input  wire         clo,
	input  wire         hlt_n,
	input  wire         hlt,
	input  wire         wx,
	input  wire         cycle,
	input  wire         irq,
	input  wire         strob1,
	input  wire         strob2,
	input  wire         ekc_1,
	input  wire         ekc_2,
	input  wire         md,
	input  wire         p4,
	input  wire         p2,
	input  wire         ssp,
	input  wire         j,
	input  wire         bcoc,
	input  wire         zs,
	input  wire [15:0]  ir,
	input  wire         slg,
	input  wire         lg_inc,
	input  wire         i1,
	input  wire         w_phase,
	input  wire         shc,
	input  wire         lk_load,
	input  wire         lk_dec,
	output logic        run,
	output logic        wait_q,
	output logic        kc,
	output logic        pc,
	output logic        sp0,
	output logic        sp1,
	output logic        si1,
	output logic        p,
	output logic        mc_3,
	output logic [pm_pkg::lg_width-1:0] lg,
	output logic [pm_pkg::lg_width-1:0] reg_sel,
	output logic [pm_pkg::lk_width-1:0] lk,
	output logic        lk_zero
);

	pm_pkg::ir_word_t ir_w;
	logic ekc;
	logic dpr;
	logic dprzerw;

	// raw bus word seen through both decodings
	assign ir_w = pm_pkg::ir_word_t'(ir);

	// timer to control cycle state
	pm_cycle_if cyc ();

	pm_ctl u_ctl (
		.__clk   (__clk),
		.M95_10  (M95_10),
		.start   (start),
		.stop    (stop),
		.clo     (clo),
		.hlt_n   (hlt_n),
		.hlt     (hlt),
		.wx      (wx),
		.cycle   (cycle),
		.irq     (irq),
		.strob1  (strob1),
		.strob2  (strob2),
		.ekc_1   (ekc_1),
		.ekc_2   (ekc_2),
		.md      (md),
		.p4      (p4),
		.p2      (p2),
		.ssp     (ssp),
		.j       (j),
		.bcoc    (bcoc),
		.zs      (zs),
		.cyc     (cyc),
		.ekc     (ekc),
		.dpr     (dpr),
		.dprzerw (dprzerw),
		.run     (run),
		.wait_q  (wait_q),
		.sp0     (sp0),
		.sp1     (sp1),
		.si1     (si1),
		.p       (p),
		.mc_3    (mc_3)
	);

	pm_kcpc u_kcpc (
		.__clk   (__clk),
		.M95_10  (M95_10),
		.ekc     (ekc),
		.dpr     (dpr),
		.dprzerw (dprzerw),
		.cyc     (cyc)
	);

	// one-shot levels to the pins
	assign kc = cyc.kc;
	assign pc = cyc.pc;

	pm_group_cnt u_group_cnt (
		.__clk   (__clk),
		.M95_10  (M95_10),
		.ir      (ir_w),
		.slg     (slg),
		.strob1  (strob1),
		.lg_inc  (lg_inc),
		.i1      (i1),
		.w_phase (w_phase),
		.lg      (lg),
		.reg_sel (reg_sel)
	);

	pm_step_cnt u_step_cnt (
		.__clk   (__clk),
		.M95_10  (M95_10),
		.ir      (ir_w),
		.shc     (shc),
		.lk_load (lk_load),
		.strob1  (strob1),
		.lk_dec  (lk_dec),
		.lk      (lk),
		.lk_zero (lk_zero)
	);

endmodule

`default_nettype wire

//--- verif/pm_checker.sv
`default_nettype none

module pm_checker (
	input  wire        __clk,
	input  wire        chk_en,
	input  wire [19:0] exp_v,
	input  wire        run,
	input  wire        wait_q,
	input  wire        kc,
	input  wire        pc,
	input  wire        sp0,
	input  wire        sp1,
	input  wire        si1,
	input  wire        p,
	input  wire        mc_3,
	input  wire [2:0]  lg,
	input  wire [2:0]  reg_sel,
	input  wire [3:0]  lk,
	input  wire        lk_zero,
	output int         err_cnt,
	output int         chk_cnt
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
	end

	// one signal against its expected value
	task automatic compare(input string name, input logic [7:0] want,
		input logic [7:0] got);
		chk_cnt = chk_cnt + 1;
		if (got !== want) begin
			err_cnt = err_cnt + 1;
			$display("FAIL %s: expected %0h, got %0h at %0t ns", name, want, got, $time);
		end
	endtask

	// mid-cycle sample
	// inputs move 1 ns after the rising edge, so outputs are settled here
	always @(negedge __clk) begin
		if (chk_en) begin
			// run-control levels
			compare("run", 8'(exp_v[19]), 8'(run));
			compare("wait_q", 8'(exp_v[18]), 8'(wait_q));
			// timer pulses
			compare("kc", 8'(exp_v[17]), 8'(kc));
			compare("pc", 8'(exp_v[16]), 8'(pc));
			// cycle type decode
			compare("sp0", 8'(exp_v[15]), 8'(sp0));
			compare("sp1", 8'(exp_v[14]), 8'(sp1));
			compare("si1", 8'(exp_v[13]), 8'(si1));
			// branch and premodification
			compare("p", 8'(exp_v[12]), 8'(p));
			compare("mc_3", 8'(exp_v[11]), 8'(mc_3));
			// group counter and selector
			compare("lg", 8'(exp_v[10:8]), 8'(lg));
			compare("reg_sel", 8'(exp_v[7:5]), 8'(reg_sel));
			// step counter
			compare("lk", 8'(exp_v[4:1]), 8'(lk));
			compare("lk_zero", 8'(exp_v[0]), 8'(lk_zero));
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_pm.sv
`default_nettype none

module tb_pm;

	timeunit 1ns;
	timeprecision 100ps;

	// dut inputs
	logic        __clk;
	logic        M95_10;
	logic        start;
	logic        stop;
	logic        clo;
	logic        hlt_n;
	logic        hlt;
	logic        wx;
	logic        cycle;
	logic        irq;
	logic        strob1;
	logic        strob2;
	logic        ekc_1;
	logic        ekc_2;
	logic        md;
	logic        p4;
	logic        p2;
	logic        ssp;
	logic        j;
	logic        bcoc;
	logic        zs;
	logic [15:0] ir;
	logic        slg;
	logic        lg_inc;
	logic        i1;
	logic        w_phase;
	logic        shc;
	logic        lk_load;
	logic        lk_dec;

	// dut outputs
	logic        run;
	logic        wait_q;
	logic        kc;
	logic        pc;
	logic        sp0;
	logic        sp1;
	logic        si1;
	logic        p;
	logic        mc_3;
	logic [2:0]  lg;
	logic [2:0]  reg_sel;
	logic [3:0]  lk;
	logic        lk_zero;

	// to and from the checker
	logic        chk_en;
	logic [19:0] exp_v;
	int          err_cnt;
	int          chk_cnt;

	// one entry per vector line
	logic [41:0] in_q [$];
	logic [19:0] exp_q [$];
	int          bad_lines;

	// run length guard
	int          cycles;
	int          cycle_limit;

	pm_top DUT (.*);

	pm_checker u_checker (.*);

	initial begin
		__clk = 1'b0;
		forever #5 __clk = ~__clk;
	end

	// unpack one vector onto the input pins
	task automatic apply_inputs(input logic [41:0] v);
		{start, stop, clo, hlt_n, hlt, wx, cycle, irq,
		 strob1, strob2, ekc_1, ekc_2,
		 md, p4, p2, ssp, j, bcoc, zs,
		 ir,
		 slg, lg_inc, i1, w_phase,
		 shc, lk_load, lk_dec} = v;
	endtask

	// read the whole vector file up front
	task automatic load_vectors;
		int          fd;
		int          n;
		string       line;
		logic [7:0]  f_ctl;
		logic [3:0]  f_str;
		logic [6:0]  f_mod;
		logic [15:0] f_ir;
		logic [3:0]  f_grp;
		logic [2:0]  f_stp;
		logic [3:0]  f_lvl;
		logic [4:0]  f_cyc;
		logic [2:0]  f_lg;
		logic [2:0]  f_rs;
		logic [3:0]  f_lk;
		logic        f_lkz;
		fd = $fopen("verif/pm_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/pm_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// skip comments and blank lines
				if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%b %b %b %h %b %b %b %b %h %h %h %b",
						f_ctl, f_str, f_mod, f_ir, f_grp, f_stp,
						f_lvl, f_cyc, f_lg, f_rs, f_lk, f_lkz);
					if (n == 12) begin
						in_q.push_back({f_ctl, f_str, f_mod, f_ir, f_grp, f_stp});
						exp_q.push_back({f_lvl, f_cyc, f_lg, f_rs, f_lk, f_lkz});
					end else begin
						bad_lines = bad_lines + 1;
						$display("malformed vector line: %s", line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// line k drives at edge k, its outputs are checked one cycle later
	task automatic run_vectors;
		M95_10 = 1'b1;
		apply_inputs(in_q[0]);
		// reset state: all levels low, step counter empty
		exp_v  = 20'h00001;
		chk_en = 1'b1;
		for (int k = 1; k <= in_q.size(); k++) begin
			@(posedge __clk);
			#1;
			if (k < in_q.size())
				apply_inputs(in_q[k]);
			else
				apply_inputs('0);
			exp_v = exp_q[k-1];
		end
		// let the last check happen
		@(posedge __clk);
		#1;
		chk_en = 1'b0;
	endtask

	initial begin
		M95_10      = 1'b0;
		chk_en      = 1'b0;
		exp_v       = '0;
		bad_lines   = 0;
		cycles      = 0;
		cycle_limit = 20;
		apply_inputs('0);
		load_vectors();
		cycle_limit = in_q.size() + 20;
		// reset held for three clocks
		repeat (3) @(posedge __clk);
		#1;
		if (in_q.size() == 0)
			$display("no test vectors were read, nothing was checked");
		else
			run_vectors();
		$display("checks %0d, errors %0d, bad vector lines %0d",
			chk_cnt, err_cnt, bad_lines);
		if (in_q.size() > 0 && chk_cnt > 0 && err_cnt == 0 && bad_lines == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// cycle counter, stops a stuck run
	always @(posedge __clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not end within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/pm_vectors.txt
# in: ctl(start stop clo hlt_n hlt wx cycle irq) str(strob1 strob2 ekc_1 ekc_2)
#     mod(md p4 p2 ssp j bcoc zs) ir(hex) grp(slg lg_inc i1 w_phase) stp(shc lk_load lk_dec)
# out after next edge: lvl(run wait_q kc pc) cyc(sp0 sp1 si1 p mc_3) lg reg_sel lk lk_zero
# reg_sel is as seen with the w_phase of the following line
00000000 0000 0000000 0000 0000 000 0000 00000 0 0 0 1
10000000 0000 0000000 0000 0000 000 1000 00000 0 0 0 1
00000000 0010 0000000 0000 0000 000 1010 00000 0 0 0 1
00000000 0000 0000000 0000 0000 000 1010 00000 0 0 0 1
00000000 0000 0000000 0000 0000 000 1010 00000 0 0 0 1
00000000 0000 0000000 0000 0000 000 1001 01000 0 0 0 1
00000000 0000 0000000 0000 0000 000 1001 01000 0 0 0 1
00000000 0000 0000000 0000 0000 000 1000 00000 0 0 0 1
# hlt at wx, then interrupt cycle releases wait
00001100 0000 0000000 0000 0000 000 0100 00000 0 0 0 1
00000001 0001 0000000 0000 0000 000 0110 00000 0 0 0 1
00000001 0000 0000000 0000 0000 000 0110 00000 0 0 0 1
00000001 0000 0000000 0000 0000 000 0110 00000 0 0 0 1
00000001 0000 0000000 0000 0000 000 0101 00100 0 0 0 1
00000000 0000 0000000 0000 0000 000 1001 00100 0 0 0 1
00000000 0000 0000000 0000 0000 000 1000 00000 0 0 0 1
# stop, then a cycle with run low, second ekc ignored
01000000 0000 0000000 0000 0000 000 0000 00000 0 0 0 1
00000000 0010 0000000 0000 0000 000 0010 00000 0 0 0 1
00000000 0010 0000000 0000 0000 000 0010 00000 0 0 0 1
00000000 0000 0000000 0000 0000 000 0010 00000 0 0 0 1
00000000 0000 0000000 0000 0000 000 0001 10000 0 0 0 1
00000000 0000 0000000 0000 0000 000 0001 10000 0 0 0 1
00000000 0000 0000000 0000 0000 000 0000 00000 0 0 0 1
# premodification count, then branch indicator
00000100 1000 1000000 0000 0000 000 0000 00000 0 0 0 1
00000100 1000 1000000 0000 0000 000 0000 00000 0 0 0 1
00000100 1000 1000000 0000 0000 000 0000 00001 0 0 0 1
00000000 0000 1100000 0000 0000 000 0000 00001 0 0 0 1
00000000 0000 0100000 0000 0000 000 0000 00000 0 0 0 1
00000000 1000 0001010 0000 0000 000 0000 00010 0 0 0 1
00000000 1000 0011010 0000 0000 000 0000 00000 0 0 0 1
00000000 1000 0001111 0000 0000 000 0000 00010 0 0 0 1
00000000 0000 0001010 0000 0000 000 0000 00010 0 0 0 1
00000000 1000 0001110 0000 0000 000 0000 00000 0 0 0 1
# group counter
00000000 0000 0000000 0373 1001 000 0000 00000 5 5 0 1
00000000 1000 0000000 0000 0101 000 0000 00000 6 6 0 1
00000000 1000 0000000 0000 0101 000 0000 00000 7 0 0 1
00000000 0000 0000000 0000 0000 000 0000 00000 7 7 0 1
00000000 0000 0000000 0000 0101 000 0000 00000 7 0 0 1
00000000 1000 0000000 0000 0110 000 0000 00000 0 0 0 1
# step counter
00000000 0000 0000000 0373 0000 110 0000 00000 0 0 b 0
00000000 1000 0000000 0000 0000 001 0000 00000 0 0 a 0
00000000 0000 0000000 0010 0000 010 0000 00000 0 0 2 0
00000000 1000 0000000 0000 0000 001 0000 00000 0 0 1 0
00000000 0000 0000000 0000 0000 001 0000 00000 0 0 1 0
00000000 1000 0000000 0000 0000 001 0000 00000 0 0 0 1
00000000 1000 0000000 0000 0000 001 0000 00000 0 0 0 1
00000000 0000 0000000 0000 0000 000 0000 00000 0 0 0 1

//--- filelist.f
hw/pm_pkg.sv
hw/pm_cycle_if.sv
hw/pm_kcpc.sv
hw/pm_group_cnt.sv
hw/pm_step_cnt.sv
hw/pm_ctl.sv
hw/pm_top.sv
verif/pm_checker.sv
verif/tb_pm.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_pm
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
